// ==== logic/retirePkg.sv ====
// Shared types and constants for the retire end; imported by every RTL module of the MEM/WB path

package retirePkg;

   //////////////////////////////
   // Widths
   //////////////////////////////

   // Data word and instruction word
   typedef logic [15:0] wordT;

   // Register number for the eight architectural registers
   typedef logic [2:0] regIdxT;

   // Top five instruction bits
   typedef logic [4:0] opcodeT;

   //////////////////////////////
   // Decode selects
   //////////////////////////////

   // Destination field choice
   typedef enum logic [1:0] {
      dstRd   = 2'b00,   // instruction[7:5]
      dstRs   = 2'b01,   // instruction[10:8]
      dstImm  = 2'b10,   // instruction[4:2]
      dstLink = 2'b11    // fixed R7
   } regDstE;

   // Write data choice
   typedef enum logic [1:0] {
      srcPc  = 2'b00,
      srcMem = 2'b01,
      srcAlu = 2'b10,
      srcReg = 2'b11
   } regSrcE;

   // Link register for JAL and JALR
   localparam regIdxT linkReg = 3'd7;

   // Default register file depth
   localparam int numRegs = 8;

endpackage

// ==== logic/memWbLatch.sv ====
// MEM/WB pipeline register; holds the memory stage result for write-back, with stall and flush

module memWbLatch (
   input  logic            clk,
   input  logic            rstN,
   input  logic            stall,
   input  logic            flush,
   input  logic            inValid,
   input  retirePkg::wordT instruction,
   input  retirePkg::wordT incrPc,
   input  retirePkg::wordT memData,
   input  retirePkg::wordT aluData,
   input  retirePkg::wordT regData,
   input  logic            regWrt,
   output logic            validQ,
   output retirePkg::wordT instrQ,
   output retirePkg::wordT incrPcQ,
   output retirePkg::wordT memDataQ,
   output retirePkg::wordT aluDataQ,
   output retirePkg::wordT regDataQ,
   output logic            regWrtQ
);

   //////////////////////////////
   // Control bits
   //////////////////////////////

   // Flush beats stall and turns the slot into a bubble
   always_ff @(posedge clk) begin
      if (!rstN) begin
         validQ  <= 1'b0;
         regWrtQ <= 1'b0;
      end else if (flush) begin
         validQ  <= 1'b0;
         regWrtQ <= 1'b0;
      end else if (!stall) begin
         validQ  <= inValid;
         regWrtQ <= regWrt;
      end
   end

   //////////////////////////////
   // Payload
   //////////////////////////////

   // Held while stalled, so the same write repeats each cycle
   always_ff @(posedge clk) begin
      if (!stall) begin
         instrQ   <= instruction;
         incrPcQ  <= incrPc;
         memDataQ <= memData;
         aluDataQ <= aluData;
         regDataQ <= regData;
      end
   end

   // Valid must come out of reset clean, write enable depends on it
   validKnown : assert property (@(posedge clk) disable iff (!rstN) !$isunknown(validQ));

endmodule

// ==== logic/destParser.sv ====
// Destination register decoder; maps an instruction to the register it writes, shared with hazard logic

module destParser (
   input  retirePkg::wordT   instruction,
   output retirePkg::regIdxT destReg
);

   import retirePkg::*;

   opcodeT opcode;
   regDstE dstSel;

   assign opcode = instruction[15:11];

   //////////////////////////////
   // Field choice
   //////////////////////////////

   always_comb begin
      // JAL, JALR always link through R7
      if (opcode[4:1] == 4'b0011) begin
         dstSel = dstLink;
      // Reg-reg ALU and compares, 11001 up to 11111
      end else if ((opcode[4:3] == 2'b11) && (opcode[2:0] != 3'b000)) begin
         dstSel = dstImm;
      // LBI plus the 100xx group, LD excluded
      end else if ((opcode == 5'b11000) ||
                   ((opcode[4:2] == 3'b100) && (opcode[1:0] != 2'b01))) begin
         dstSel = dstRs;
      // Everything else names rd in bits 7:5
      end else begin
         dstSel = dstRd;
      end
   end

   // Pull the chosen field out of the instruction
   always_comb begin
      case (dstSel)
         dstRd:   destReg = instruction[7:5];
         dstRs:   destReg = instruction[10:8];
         dstImm:  destReg = instruction[4:2];
         default: destReg = linkReg;
      endcase
   end

endmodule

// ==== logic/writeBack.sv ====
// Write-back stage; selects write data and target register from the latched MEM/WB contents

module writeBack (
   input  logic              validQ,
   input  retirePkg::wordT   instrQ,
   input  retirePkg::wordT   incrPcQ,
   input  retirePkg::wordT   memDataQ,
   input  retirePkg::wordT   aluDataQ,
   input  retirePkg::wordT   regDataQ,
   input  logic              regWrtQ,
   output logic              wrEn,
   output retirePkg::regIdxT wrAddr,
   output retirePkg::wordT   wrData
);

   import retirePkg::*;

   opcodeT opcode;
   regSrcE srcSel;

   assign opcode = instrQ[15:11];

   //////////////////////////////
   // Data source decode
   //////////////////////////////

   always_comb begin
      // LBI and SLBI take the operand straight through
      if ((opcode == 5'b11000) || (opcode == 5'b10010)) begin
         srcSel = srcReg;
      // LD is the only memory reader
      end else if (opcode == 5'b10001) begin
         srcSel = srcMem;
      // Links and the 0000x group take PC+2
      end else if ((opcode[4:1] == 4'b0000) || (opcode[4:1] == 4'b0011)) begin
         srcSel = srcPc;
      end else begin
         srcSel = srcAlu;
      end
   end

   //////////////////////////////
   // Write port drive
   //////////////////////////////

   always_comb begin
      case (srcSel)
         srcPc:   wrData = incrPcQ;
         srcMem:  wrData = memDataQ;
         srcAlu:  wrData = aluDataQ;
         default: wrData = regDataQ;
      endcase
   end

   // regWrt comes from decode, the bubble bit gates it here
   assign wrEn = validQ & regWrtQ;

   // Same decoder the hazard unit would use
   destParser iParser (
      .instruction (instrQ),
      .destReg     (wrAddr)
   );

   // A real write never carries X into the file
   always_comb begin
      if (wrEn) begin
         wrKnown : assert final (!$isunknown({wrAddr, wrData}));
      end
   end

endmodule

// ==== logic/regFile.sv ====
// Register file for the retire end; one write port from write-back, two bypassed reads for decode

module regFile #(
   parameter int numRegs = retirePkg::numRegs
) (
   input  logic              clk,
   input  logic              rstN,
   input  logic              wrEn,
   input  retirePkg::regIdxT wrAddr,
   input  retirePkg::wordT   wrData,
   input  retirePkg::regIdxT rdAddrA,
   input  retirePkg::regIdxT rdAddrB,
   output retirePkg::wordT   rdDataA,
   output retirePkg::wordT   rdDataB
);

   import retirePkg::*;

   wordT regs [numRegs];

   //////////////////////////////
   // Write port
   //////////////////////////////

   // Architectural state starts at zero
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   //////////////////////////////
   // Read ports
   //////////////////////////////

   // Write this cycle wins over the stored copy
   always_comb begin
      if (wrEn && (wrAddr == rdAddrA)) begin
         rdDataA = wrData;
      end else begin
         rdDataA = regs[rdAddrA];
      end
   end

   // Port B, same bypass
   always_comb begin
      if (wrEn && (wrAddr == rdAddrB)) begin
         rdDataB = wrData;
      end else begin
         rdDataB = regs[rdAddrB];
      end
   end

   // Decoded target has to fit the configured depth
   addrInRange : assert property (@(posedge clk) disable iff (!rstN)
      wrEn |-> (int'(wrAddr) < numRegs));

endmodule

// ==== logic/retireTop.sv ====
// Retire end top level; MEM/WB latch feeding write-back and the register file

module retireTop #(
   parameter int numRegs = retirePkg::numRegs
) (
   input  logic              clk,
   input  logic              rstN,
   input  logic              inValid,
   input  logic              stall,
   input  logic              flush,
   input  retirePkg::wordT   instruction,
   input  retirePkg::wordT   incrPc,
   input  retirePkg::wordT   memData,
   input  retirePkg::wordT   aluData,
   input  retirePkg::wordT   regData,
   input  logic              regWrt,
   input  retirePkg::regIdxT rdAddrA,
   input  retirePkg::regIdxT rdAddrB,
   output retirePkg::wordT   rdDataA,
   output retirePkg::wordT   rdDataB,
   output retirePkg::regIdxT wbRd,
   output logic              wbWrite
);

   import retirePkg::*;

   // Latched stage contents
   logic validQ;
   logic regWrtQ;
   wordT instrQ;
   wordT incrPcQ;
   wordT memDataQ;
   wordT aluDataQ;
   wordT regDataQ;
   wordT wrData;

   //////////////////////////////
   // MEM/WB latch
   //////////////////////////////

   memWbLatch iLatch (
      .clk         (clk),
      .rstN        (rstN),
      .stall       (stall),
      .flush       (flush),
      .inValid     (inValid),
      .instruction (instruction),
      .incrPc      (incrPc),
      .memData     (memData),
      .aluData     (aluData),
      .regData     (regData),
      .regWrt      (regWrt),
      .validQ      (validQ),
      .instrQ      (instrQ),
      .incrPcQ     (incrPcQ),
      .memDataQ    (memDataQ),
      .aluDataQ    (aluDataQ),
      .regDataQ    (regDataQ),
      .regWrtQ     (regWrtQ)
   );

   //////////////////////////////
   // Write-back
   //////////////////////////////

   // Write port doubles as the forwarding export
   writeBack iWriteBack (
      .validQ   (validQ),
      .instrQ   (instrQ),
      .incrPcQ  (incrPcQ),
      .memDataQ (memDataQ),
      .aluDataQ (aluDataQ),
      .regDataQ (regDataQ),
      .regWrtQ  (regWrtQ),
      .wrEn     (wbWrite),
      .wrAddr   (wbRd),
      .wrData   (wrData)
   );

   //////////////////////////////
   // Register file
   //////////////////////////////

   regFile #(
      .numRegs (numRegs)
   ) iRegFile (
      .clk     (clk),
      .rstN    (rstN),
      .wrEn    (wbWrite),
      .wrAddr  (wbRd),
      .wrData  (wrData),
      .rdAddrA (rdAddrA),
      .rdAddrB (rdAddrB),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB)
   );

endmodule

// ==== verification/retireTb.sv ====
// Self-checking testbench for retireTop; replays the stimulus file one step per clock and checks it

module retireTb;

   import retirePkg::*;

   //////////////////////////////
   // Setup
   //////////////////////////////

   localparam int    clkHalf   = 50;
   localparam int    checkLead = 10;
   localparam int    maxLines  = 200;
   localparam string stimFile  = "verification/retireInput.txt";

   logic   clk = 1'b0;
   logic   rstN;
   logic   inValid;
   logic   stall;
   logic   flush;
   wordT   instruction;
   wordT   incrPc;
   wordT   memData;
   wordT   aluData;
   wordT   regData;
   logic   regWrt;
   regIdxT rdAddrA;
   regIdxT rdAddrB;
   wordT   rdDataA;
   wordT   rdDataB;
   regIdxT wbRd;
   logic   wbWrite;

   // Wrong values, and failures of the run itself
   int errorCount;
   int failCount;
   int stepCount;

   // 100 unit period
   always #clkHalf clk = ~clk;

   retireTop #(
      .numRegs (numRegs)
   ) i_retireTop (
      .clk         (clk),
      .rstN        (rstN),
      .inValid     (inValid),
      .stall       (stall),
      .flush       (flush),
      .instruction (instruction),
      .incrPc      (incrPc),
      .memData     (memData),
      .aluData     (aluData),
      .regData     (regData),
      .regWrt      (regWrt),
      .rdAddrA     (rdAddrA),
      .rdAddrB     (rdAddrB),
      .rdDataA     (rdDataA),
      .rdDataB     (rdDataB),
      .wbRd        (wbRd),
      .wbWrite     (wbWrite)
   );

   //////////////////////////////
   // Compare tasks
   //////////////////////////////

   task automatic checkWord(input string sigName, input wordT expVal, input wordT actVal);
      if (actVal !== expVal) begin
         $display("** Error at %0t: %s expected %h, actual %h", $time, sigName, expVal, actVal);
         errorCount++;
      end
   endtask

   task automatic checkIdx(input string sigName, input regIdxT expVal, input regIdxT actVal);
      if (actVal !== expVal) begin
         $display("** Error at %0t: %s expected %h, actual %h", $time, sigName, expVal, actVal);
         errorCount++;
      end
   endtask

   task automatic checkBit(input string sigName, input logic expVal, input logic actVal);
      if (actVal !== expVal) begin
         $display("** Error at %0t: %s expected %b, actual %b", $time, sigName, expVal, actVal);
         errorCount++;
      end
   endtask

   //////////////////////////////
   // Stimulus replay
   //////////////////////////////

   initial begin
      int     fd;
      int     readCount;
      int     fieldCount;
      int     lineCount;
      bit     limitHit;
      string  lineText;
      logic   vIn;
      logic   stIn;
      logic   flIn;
      logic   wrtIn;
      logic   expWr;
      wordT   insIn;
      wordT   pcIn;
      wordT   memIn;
      wordT   aluIn;
      wordT   regIn;
      wordT   expA;
      wordT   expB;
      regIdxT addrA;
      regIdxT addrB;
      regIdxT expRd;

      rstN        = 1'b0;
      inValid     = 1'b0;
      stall       = 1'b0;
      flush       = 1'b0;
      instruction = '0;
      incrPc      = '0;
      memData     = '0;
      aluData     = '0;
      regData     = '0;
      regWrt      = 1'b0;
      rdAddrA     = '0;
      rdAddrB     = '0;
      errorCount  = 0;
      failCount   = 0;
      stepCount   = 0;
      lineCount   = 0;
      limitHit    = 1'b0;

      // Two reset edges, first file step goes in on the third
      repeat (2) @(posedge clk);
      rstN <= 1'b1;

      fd = $fopen(stimFile, "r");
      if (fd == 0) begin
         $display("Could not open stimulus file %s", stimFile);
         failCount++;
      end else begin
         while (!$feof(fd) && !limitHit) begin
            if (lineCount >= maxLines) begin
               $display("Step limit of %0d lines reached before the end of the stimulus file",
                        maxLines);
               failCount++;
               limitHit = 1'b1;
            end else begin
               lineText  = "";
               readCount = $fgets(lineText, fd);
               lineCount++;
               // Comment and blank lines carry no step
               if ((readCount > 1) && (lineText.getc(0) != "/")) begin
                  fieldCount = $sscanf(lineText,
                     "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     vIn, stIn, flIn, insIn, pcIn, memIn, aluIn, regIn, wrtIn,
                     addrA, addrB, expA, expB, expRd, expWr);
                  if (fieldCount != 15) begin
                     $display("Stimulus line %0d is malformed, %0d fields read",
                              lineCount, fieldCount);
                     failCount++;
                  end else begin
                     @(posedge clk);
                     inValid     <= vIn;
                     stall       <= stIn;
                     flush       <= flIn;
                     instruction <= insIn;
                     incrPc      <= pcIn;
                     memData     <= memIn;
                     aluData     <= aluIn;
                     regData     <= regIn;
                     regWrt      <= wrtIn;
                     rdAddrA     <= addrA;
                     rdAddrB     <= addrB;
                     // Sample just ahead of the next edge
                     #(2 * clkHalf - checkLead);
                     checkWord("rdDataA", expA, rdDataA);
                     checkWord("rdDataB", expB, rdDataB);
                     checkIdx("wbRd", expRd, wbRd);
                     checkBit("wbWrite", expWr, wbWrite);
                     stepCount++;
                  end
               end
            end
         end
         $fclose(fd);
         if (stepCount == 0) begin
            $display("Stimulus file held no steps");
            failCount++;
         end
      end

      $display("Run finished: %0d steps, %0d value errors, %0d other failures",
               stepCount, errorCount, failCount);
      if ((errorCount == 0) && (failCount == 0)) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== verification/retireInput.txt ====
// Columns, hex: inValid stall flush instruction incrPc memData aluData regData regWrt
// rdAddrA rdAddrB expRdDataA expRdDataB expWbRd expWbWrite
// Reset state, all registers read zero
0 0 0 0000 0000 0000 0000 0000 0 0 1 0000 0000 0 0
0 0 0 0000 0000 0000 0000 0000 0 2 3 0000 0000 0 0
0 0 0 0000 0000 0000 0000 0000 0 4 5 0000 0000 0 0
0 0 0 0000 0000 0000 0000 0000 0 6 7 0000 0000 0 0
// LD, JAL, LBI, SLBI, ADD, ADDI, JALR with bypass reads
1 0 0 8960 0102 BEEF 1111 2222 1 0 0 0000 0000 0 0
1 0 0 3010 0204 3333 4444 5555 1 3 7 BEEF 0000 3 1
1 0 0 C455 0306 6666 7777 0055 1 7 3 0204 BEEF 7 1
1 0 0 9501 0408 8888 9999 5501 1 4 7 0055 0204 4 1
1 0 0 D958 050A AAAA 1234 BBBB 1 5 4 5501 0055 5 1
1 0 0 4143 060C CCCC 0A0A DDDD 1 6 5 1234 5501 6 1
1 0 0 3A00 070E EEEE FFFF 0F0F 1 2 6 0A0A 1234 2 1
// regWrt low, then a bubble with inValid low
1 0 0 D958 0810 1010 DEAD 2020 0 7 2 070E 0A0A 7 1
0 0 0 8960 0912 F00D 3030 4040 1 6 7 1234 070E 6 0
// SEQ held by two stall cycles
1 0 0 E004 0A14 5050 0001 6060 1 3 1 BEEF 0000 3 0
1 1 0 8960 0B16 9999 8080 9090 1 1 6 0001 1234 1 1
1 1 0 8960 0B16 9999 8080 9090 1 1 0 0001 0000 1 1
1 0 0 D958 0C18 A0A0 7777 B0B0 1 6 1 1234 0001 1 1
// JAL flushed on its own latch edge, R7 unchanged
1 0 1 3010 ABCD C0C0 D0D0 E0E0 1 6 7 7777 070E 6 1
0 0 0 0000 0000 0000 0000 0000 0 7 6 070E 7777 7 0
0 0 0 0000 0000 0000 0000 0000 0 1 7 0001 070E 0 0
// Final contents of the file
0 0 0 0000 0000 0000 0000 0000 0 2 3 0A0A BEEF 0 0
0 0 0 0000 0000 0000 0000 0000 0 4 5 0055 5501 0 0
0 0 0 0000 0000 0000 0000 0000 0 6 7 7777 070E 0 0
0 0 0 0000 0000 0000 0000 0000 0 0 1 0000 0001 0 0

// ==== filelist.f ====
logic/retirePkg.sv
logic/memWbLatch.sv
logic/destParser.sv
logic/writeBack.sv
logic/regFile.sv
logic/retireTop.sv
verification/retireTb.sv

// ==== Bender.yml ====
package:
  name: retire

sources:
  - logic/retirePkg.sv
  - logic/memWbLatch.sv
  - logic/destParser.sv
  - logic/writeBack.sv
  - logic/regFile.sv
  - logic/retireTop.sv
  - target: test
    files:
      - verification/retireTb.sv
